// File: filelist.f
+incdir+include
design/cellfifo_pkg.sv
design/cellfifo_xing_if.sv
design/syncdff.sv
design/cellfifo_wr_logic.sv
design/cellfifo_ram.sv
design/cellfifo_rd_logic.sv
design/cellfifo_top.sv
verif/cellfifo_tb.sv

// File: Bender.yml
package:
  name: cellfifo

export_include_dirs:
  - include

sources:
  - files:
      - design/cellfifo_pkg.sv
      - design/cellfifo_xing_if.sv
      - design/syncdff.sv
      - design/cellfifo_wr_logic.sv
      - design/cellfifo_ram.sv
      - design/cellfifo_rd_logic.sv
      - design/cellfifo_top.sv
  - target: simulation
    files:
      - verif/cellfifo_tb.sv

// File: verif/cellfifo_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cellfifo_macros.svh"

module cellfifo_tb;

    import cellfifo_pkg::*;

    localparam int CAPACITY        = 2 ** `CELLFIFO_ADDR_SIZE - 1;
    localparam int RAM_LATENCY     = `CELLFIFO_RAM_LATENCY;
    localparam int DATA_SIZE       = `CELLFIFO_DATA_SIZE;
    localparam int STATUS_W        = `CELLFIFO_ADDR_SIZE + 4;
    localparam int BURST_LEN       = 10;
    localparam int FULL_TRIES      = 20;
    localparam int RAND_CYCLES     = 500;
    // resets, idle gaps and drains
    localparam int OVERHEAD_CYCLES = 470;
    localparam int TIMEOUT_CYCLES  = 4 * (BURST_LEN + FULL_TRIES + RAND_CYCLES + OVERHEAD_CYCLES);
    localparam logic [31:0] RAND_SEED = 32'h9cf899fc;

    logic         clk;
    logic         rst_n;
    logic         wr_req;
    cf_data_t     wr_data;
    logic         wr_eoc;
    logic         wr_full;
    logic         wr_afull;
    cf_addr_t     wr_used;
    logic         rd_req;
    logic         rd_rdy;
    logic         rd_vld;
    cf_data_t     rd_data;
    logic         rd_eoc;
    logic         rd_empty;
    logic         rd_aempty;
    cf_addr_t     rd_used;

    // words inside the fifo with eoc above the payload
    cf_ram_word_t expect_q [$];
    logic         hs_q;
    cf_ram_word_t exp_word;
    int           cycle_cnt;

    cellfifo_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_data   (wr_data),
        .wr_eoc    (wr_eoc),
        .wr_full   (wr_full),
        .wr_afull  (wr_afull),
        .wr_used   (wr_used),
        .rd_req    (rd_req),
        .rd_rdy    (rd_rdy),
        .rd_vld    (rd_vld),
        .rd_data   (rd_data),
        .rd_eoc    (rd_eoc),
        .rd_empty  (rd_empty),
        .rd_aempty (rd_aempty),
        .rd_used   (rd_used)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // ******************************
    // helpers and reference
    // ******************************

    task automatic raise_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // wr_full is steady until the rising edge that takes the write
    task automatic drive_cycle(input logic wreq, input cf_data_t data, input logic eoc,
                               input logic rreq);
        @(negedge clk);
        wr_req  = wreq;
        wr_data = data;
        wr_eoc  = eoc;
        rd_req  = rreq;
        if (wreq && !wr_full)
            expect_q.push_back({eoc, data});
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
            drive_cycle(1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic drain_model();
        while (expect_q.size() != 0)
            drive_cycle(1'b0, '0, 1'b0, 1'b1);
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
    endtask

    function automatic cf_ram_word_t next_expected();
        cf_ram_word_t word;
        word = expect_q.pop_front();
        return word;
    endfunction

    // flags at rest with held words already out of the ram in the read pipeline
    function automatic logic [STATUS_W-1:0] settled_status(input int size, input int held);
        int used;
        used = size - held;
        return {cf_addr_t'(used), used == CAPACITY, used >= CAPACITY - `CELLFIFO_AFULL_NUM,
                used <= `CELLFIFO_AEMPTY_NUM, used == 0};
    endfunction

    task automatic check_settled();
        logic [STATUS_W-1:0] dut_status;
        logic                match;
        int                  size;
        int                  min_held;
        int                  max_held;
        size       = expect_q.size();
        dut_status = {wr_used, wr_full, wr_afull, rd_aempty, rd_empty};
        // head word plus maybe one more sit past the ram read port
        min_held   = (size == 0) ? 0 : 1;
        max_held   = (size < RAM_LATENCY) ? size : RAM_LATENCY;
        match      = 1'b0;
        for (int held = min_held; held <= max_held; held++)
            if (dut_status == settled_status(size, held))
                match = 1'b1;
        assert (match && rd_used == wr_used && rd_rdy == (size != 0))
        else
            raise_error($sformatf("settled flags for %0d words: used %0d/%0d flags %04b rdy %0b",
                                  size, wr_used, rd_used, dut_status[3:0], rd_rdy));
    endtask

    // ******************************
    // read side compare
    // ******************************

    // each rd_vld follows a handshake and carries the head of the model
    always @(posedge clk)
    begin
        if (!rst_n)
            hs_q = 1'b0;
        else
        begin
            assert (rd_vld == hs_q)
            else
                raise_error($sformatf("rd_vld is %0b, handshake said %0b", rd_vld, hs_q));
            if (rd_vld)
            begin
                assert (expect_q.size() != 0)
                else
                    raise_error("word delivered while the model queue is empty");
                exp_word = next_expected();
                assert ({rd_eoc, rd_data} == exp_word)
                else
                    raise_error($sformatf("read eoc %0b data %08h, expected eoc %0b data %08h",
                                          rd_eoc, rd_data,
                                          exp_word[DATA_SIZE], exp_word[DATA_SIZE-1:0]));
            end
            hs_q = rd_req & rd_rdy;
        end
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "stopped by timeout");
    end

    // ******************************
    // stimulus
    // ******************************

    initial
    begin
        int   accepted;
        logic seen_full;
        void'($urandom(RAND_SEED));
        rst_n   = 1'b0;
        wr_req  = 1'b0;
        wr_data = '0;
        wr_eoc  = 1'b0;
        rd_req  = 1'b0;
        repeat (3)
            @(negedge clk);
        rst_n = 1'b1;

        // reset state holds until the first write
        repeat (10)
        begin
            @(negedge clk);
            assert (!rd_rdy && !rd_vld && !wr_full && !wr_afull && rd_empty && rd_aempty)
            else
                raise_error($sformatf("reset flags rdy %0b vld %0b full %0b afull %0b",
                                      rd_rdy, rd_vld, wr_full, wr_afull));
        end

        // in order burst with eoc on every fourth word
        for (int i = 0; i < BURST_LEN; i++)
            drive_cycle(1'b1, cf_data_t'($urandom), (i % 4) == 3, 1'b1);
        drain_model();
        idle_cycles(20);

        // one word first so the prefetch takes it before the fill
        drive_cycle(1'b1, cf_data_t'($urandom), 1'b1, 1'b0);
        idle_cycles(30);
        accepted  = 0;
        seen_full = 1'b0;
        for (int i = 1; i < FULL_TRIES + 10; i++)
        begin
            if (i < FULL_TRIES)
                drive_cycle(1'b1, cf_data_t'($urandom), (i % 4) == 3, 1'b0);
            else
                drive_cycle(1'b0, '0, 1'b0, 1'b0);
            if (seen_full)
            begin
                assert (wr_full)
                else
                    raise_error("wr_full fell while no word was read");
            end
            if (wr_full)
                seen_full = 1'b1;
            else if (i < FULL_TRIES)
                accepted++;
        end
        assert (seen_full && accepted == CAPACITY)
        else
            raise_error($sformatf("fill took %0d words, expected %0d", accepted, CAPACITY));
        drain_model();
        idle_cycles(20);
        assert (rd_empty)
        else
            raise_error("rd_empty is 0 after the fifo was drained");

        // random traffic on both sides
        for (int i = 0; i < RAND_CYCLES; i++)
            drive_cycle($urandom % 2, cf_data_t'($urandom), $urandom % 2, ($urandom % 5) < 2);
        idle_cycles(30);
        check_settled();

        drain_model();
        idle_cycles(5);
        if (expect_q.size() == 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
            raise_error("model queue is not empty at the end of the run");
    end

endmodule

`default_nettype wire

// File: design/cellfifo_top.sv
`timescale 1ns/10ps
`default_nettype none

module cellfifo_top (
    input  wire                         clk,
    input  wire                         rst_n,
    // write side
    input  wire                         wr_req,
    input  wire cellfifo_pkg::cf_data_t wr_data,
    input  wire                         wr_eoc,
    output logic                        wr_full,
    output logic                        wr_afull,
    output cellfifo_pkg::cf_addr_t      wr_used,
    // read side
    input  wire                         rd_req,
    output logic                        rd_rdy,
    output logic                        rd_vld,
    output cellfifo_pkg::cf_data_t      rd_data,
    output logic                        rd_eoc,
    output logic                        rd_empty,
    output logic                        rd_aempty,
    output cellfifo_pkg::cf_addr_t      rd_used
);

    import cellfifo_pkg::*;

    logic         ram_wen;
    cf_addr_t     ram_waddr;
    cf_ram_word_t ram_wdata;
    logic         ram_rcken;
    cf_addr_t     ram_raddr;
    cf_ram_word_t ram_rdata;

    // pointer crossing between the two sides
    cellfifo_xing_if u_xing ();

    cellfifo_wr_logic u_wr_logic (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_data   (wr_data),
        .wr_eoc    (wr_eoc),
        .wr_full   (wr_full),
        .wr_afull  (wr_afull),
        .wr_used   (wr_used),
        .xing      (u_xing.wr_side),
        .ram_wen   (ram_wen),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata)
    );

    cellfifo_ram u_ram (
        .clk   (clk),
        .wen   (ram_wen),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .rcken (ram_rcken),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    cellfifo_rd_logic u_rd_logic (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req    (rd_req),
        .rd_rdy    (rd_rdy),
        .rd_vld    (rd_vld),
        .rd_eoc    (rd_eoc),
        .rd_data   (rd_data),
        .rd_empty  (rd_empty),
        .rd_aempty (rd_aempty),
        .rd_used   (rd_used),
        .xing      (u_xing.rd_side),
        .ram_rcken (ram_rcken),
        .ram_raddr (ram_raddr),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: design/cellfifo_rd_logic.sv
`timescale 1ns/10ps
`default_nettype none

`include "cellfifo_macros.svh"

module cellfifo_rd_logic (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             rd_req,
    output logic                            rd_rdy,
    output logic                            rd_vld,
    output logic                            rd_eoc,
    output cellfifo_pkg::cf_data_t          rd_data,
    output logic                            rd_empty,
    output logic                            rd_aempty,
    output cellfifo_pkg::cf_addr_t          rd_used,
    cellfifo_xing_if.rd_side                xing,
    output logic                            ram_rcken,
    output cellfifo_pkg::cf_addr_t          ram_raddr,
    input  wire cellfifo_pkg::cf_ram_word_t ram_rdata
);

    import cellfifo_pkg::*;

    localparam int RAM_LATENCY = `CELLFIFO_RAM_LATENCY;
    localparam int DATA_SIZE   = `CELLFIFO_DATA_SIZE;

    cf_addr_t               waddr_sync1;
    cf_addr_t               waddr_sync2;
    cf_addr_t               waddr_syn;
    cf_addr_t               rd_addr;
    cf_addr_t               rd_addr_pre;
    cf_addr_t               rd_addr_gry;
    logic [RAM_LATENCY-1:0] empty_dly;
    logic                   fifo_ren;
    logic                   rd_vld_q;
    cf_ram_word_t           rd_word_q;

    // ******************************
    // write address import
    // ******************************

    // echo of the toggle lets the write side publish again
    syncdff #(
        .DATA_SIZE (1),
        .SYNC_NUM  (`CELLFIFO_SYNC_NUM)
    ) u_togf_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (xing.waddr_togf),
        .data_sync (xing.waddr_togb)
    );

    syncdff #(
        .DATA_SIZE (`CELLFIFO_ADDR_SIZE),
        .SYNC_NUM  (`CELLFIFO_SYNC_NUM)
    ) u_waddr_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (xing.waddr2rd),
        .data_sync (waddr_sync1)
    );

    // take the address only after two equal samples
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            waddr_sync2 <= '0;
            waddr_syn   <= '0;
        end
        else
        begin
            waddr_sync2 <= waddr_sync1;
            if (waddr_sync2 == waddr_sync1)
                waddr_syn <= waddr_sync2;
        end
    end

    // ******************************
    // read pointer
    // ******************************

    // read when sink asks or when nothing is prefetched yet
    assign fifo_ren    = (rd_req | ~rd_rdy) & ~rd_empty;
    assign rd_addr_pre = fifo_ren ? rd_addr + cf_addr_t'(1) : rd_addr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_addr     <= '0;
            rd_addr_gry <= '0;
        end
        else
        begin
            rd_addr     <= rd_addr_pre;
            rd_addr_gry <= rd_addr_pre ^ (rd_addr_pre >> 1);
        end
    end

    assign xing.raddr2wr = (`CELLFIFO_ASYNC_MODE == 1) ? rd_addr_gry : rd_addr;
    assign rd_used       = (`CELLFIFO_ASYNC_MODE == 1) ? waddr_syn - rd_addr
                                                       : xing.waddr2rd - rd_addr;

    // ******************************
    // flags
    // ******************************

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_empty  <= 1'b1;
            rd_aempty <= 1'b1;
        end
        else
        begin
            // last word leaving counts as empty right away
            rd_empty  <= (rd_used == '0) || ((rd_used == cf_addr_t'(1)) && fifo_ren);
            rd_aempty <= (rd_used <= cf_addr_t'(`CELLFIFO_AEMPTY_NUM));
        end
    end

    // ******************************
    // prefetch pipeline
    // ******************************

    // empty follows the data through the ram latency
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            empty_dly <= '1;
        else if (ram_rcken)
            empty_dly <= RAM_LATENCY'({empty_dly, rd_empty});
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_vld_q <= 1'b0;
        else
            rd_vld_q <= rd_rdy & rd_req;
    end

    // head word captured at the handshake for the rd_vld cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_word_q <= '0;
        else if (rd_rdy & rd_req)
            rd_word_q <= ram_rdata;
    end

    assign rd_rdy    = ~empty_dly[RAM_LATENCY-1];
    assign ram_rcken = rd_req | ~rd_rdy;
    assign ram_raddr = rd_addr;
    assign rd_vld    = rd_vld_q;
    assign rd_eoc    = rd_word_q[DATA_SIZE];
    assign rd_data   = rd_word_q[DATA_SIZE-1:0];

endmodule

`default_nettype wire

// File: design/cellfifo_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "cellfifo_macros.svh"

module cellfifo_ram (
    input  wire                             clk,
    input  wire                             wen,
    input  wire cellfifo_pkg::cf_addr_t     waddr,
    input  wire cellfifo_pkg::cf_ram_word_t wdata,
    input  wire                             rcken,
    input  wire cellfifo_pkg::cf_addr_t     raddr,
    output cellfifo_pkg::cf_ram_word_t      rdata
);

    import cellfifo_pkg::*;

    localparam int RAM_DEPTH   = 2 ** `CELLFIFO_ADDR_SIZE;
    localparam int RAM_LATENCY = `CELLFIFO_RAM_LATENCY;

    cf_ram_word_t mem [RAM_DEPTH];
    cf_addr_t     raddr_q;
    cf_ram_word_t mem_rd;

    always_ff @(posedge clk)
    begin
        if (wen)
            mem[waddr] <= wdata;
    end

    // first read stage, address sampled
    always_ff @(posedge clk)
    begin
        if (rcken)
            raddr_q <= raddr;
    end

    assign mem_rd = mem[raddr_q];

    // remaining stages, held when rcken is low
    generate
        if (RAM_LATENCY == 1)
        begin : g_no_out_reg
            assign rdata = mem_rd;
        end
        else
        begin : g_out_reg
            cf_ram_word_t out_q [RAM_LATENCY-1];

            always_ff @(posedge clk)
            begin
                if (rcken)
                begin
                    out_q[0] <= mem_rd;
                    for (int i = 1; i < RAM_LATENCY - 1; i++)
                        out_q[i] <= out_q[i-1];
                end
            end

            assign rdata = out_q[RAM_LATENCY-2];
        end
    endgenerate

endmodule

`default_nettype wire

// File: design/cellfifo_wr_logic.sv
`timescale 1ns/10ps
`default_nettype none

`include "cellfifo_macros.svh"

module cellfifo_wr_logic (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         wr_req,
    input  wire cellfifo_pkg::cf_data_t wr_data,
    input  wire                         wr_eoc,
    output logic                        wr_full,
    output logic                        wr_afull,
    output cellfifo_pkg::cf_addr_t      wr_used,
    cellfifo_xing_if.wr_side            xing,
    output logic                        ram_wen,
    output cellfifo_pkg::cf_addr_t      ram_waddr,
    output cellfifo_pkg::cf_ram_word_t  ram_wdata
);

    import cellfifo_pkg::*;

    localparam int       ADDR_SIZE   = `CELLFIFO_ADDR_SIZE;
    localparam cf_addr_t CAPACITY    = {ADDR_SIZE{1'b1}};
    localparam cf_addr_t AFULL_LEVEL = CAPACITY - cf_addr_t'(`CELLFIFO_AFULL_NUM);

    logic     wr_en;
    cf_addr_t wr_addr;
    cf_addr_t waddr_pub;
    logic     waddr_togf_q;
    logic     togb_sync;
    cf_addr_t raddr_sync;
    cf_addr_t rd_addr_bin;

    function automatic cf_addr_t gray2bin(input cf_addr_t gray);
        cf_addr_t bin;
        bin[ADDR_SIZE-1] = gray[ADDR_SIZE-1];
        for (int i = ADDR_SIZE - 2; i >= 0; i--)
            bin[i] = bin[i+1] ^ gray[i];
        return bin;
    endfunction

    // ******************************
    // write pointer and ram port
    // ******************************

    // writes while full are dropped
    assign wr_en     = wr_req & ~wr_full;
    assign ram_wen   = wr_en;
    assign ram_waddr = wr_addr;
    assign ram_wdata = {wr_eoc, wr_data};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wr_addr <= '0;
        else if (wr_en)
            wr_addr <= wr_addr + cf_addr_t'(1);
    end

    // ******************************
    // toggle handshake
    // ******************************

    syncdff #(
        .DATA_SIZE (1),
        .SYNC_NUM  (`CELLFIFO_SYNC_NUM)
    ) u_togb_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (xing.waddr_togb),
        .data_sync (togb_sync)
    );

    // new address only once the last toggle has come back
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            waddr_pub    <= '0;
            waddr_togf_q <= 1'b0;
        end
        else if (togb_sync == waddr_togf_q)
        begin
            waddr_pub    <= wr_addr;
            waddr_togf_q <= ~waddr_togf_q;
        end
    end

    assign xing.waddr2rd   = (`CELLFIFO_ASYNC_MODE == 1) ? waddr_pub : wr_addr;
    assign xing.waddr_togf = waddr_togf_q;

    // ******************************
    // read pointer import and flags
    // ******************************

    syncdff #(
        .DATA_SIZE (ADDR_SIZE),
        .SYNC_NUM  (`CELLFIFO_SYNC_NUM)
    ) u_raddr_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (xing.raddr2wr),
        .data_sync (raddr_sync)
    );

    assign rd_addr_bin = (`CELLFIFO_ASYNC_MODE == 1) ? gray2bin(raddr_sync) : xing.raddr2wr;
    assign wr_used     = wr_addr - rd_addr_bin;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_full  <= 1'b0;
            wr_afull <= 1'b0;
        end
        else
        begin
            // also covers the write that fills the last slot
            wr_full  <= (wr_used == CAPACITY) ||
                        ((wr_used == CAPACITY - cf_addr_t'(1)) && wr_en);
            wr_afull <= (wr_used >= AFULL_LEVEL);
        end
    end

endmodule

`default_nettype wire

// File: design/syncdff.sv
`timescale 1ns/10ps
`default_nettype none

module syncdff #(
    parameter int DATA_SIZE = 1,
    parameter int SYNC_NUM  = 3
)
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire  [DATA_SIZE-1:0] data_in,
    output logic [DATA_SIZE-1:0] data_sync
);

    logic [DATA_SIZE-1:0] sync_q [SYNC_NUM];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < SYNC_NUM; i++)
                sync_q[i] <= '0;
        end
        else
        begin
            sync_q[0] <= data_in;
            for (int i = 1; i < SYNC_NUM; i++)
                sync_q[i] <= sync_q[i-1];
        end
    end

    assign data_sync = sync_q[SYNC_NUM-1];

endmodule

`default_nettype wire

// File: design/cellfifo_xing_if.sv
`timescale 1ns/10ps
`default_nettype none

interface cellfifo_xing_if;

    import cellfifo_pkg::*;

    // write address published to the read side
    cf_addr_t waddr2rd;
    // toggle forward and its echo
    logic     waddr_togf;
    logic     waddr_togb;
    // read pointer, gray in async mode
    cf_addr_t raddr2wr;

    modport wr_side (
        output waddr2rd,
        output waddr_togf,
        input  waddr_togb,
        input  raddr2wr
    );

    modport rd_side (
        input  waddr2rd,
        input  waddr_togf,
        output waddr_togb,
        output raddr2wr
    );

endinterface

`default_nettype wire

// File: design/cellfifo_pkg.sv
`default_nettype none

`include "cellfifo_macros.svh"

package cellfifo_pkg;

    // ******************************
    // vector types
    // ******************************

    // pointers and fill counts
    typedef logic [`CELLFIFO_ADDR_SIZE-1:0] cf_addr_t;

    // payload word
    typedef logic [`CELLFIFO_DATA_SIZE-1:0] cf_data_t;

    // ram word, eoc flag sits above the payload
    typedef logic [`CELLFIFO_DATA_SIZE:0]   cf_ram_word_t;

endpackage

`default_nettype wire

// File: include/cellfifo_macros.svh
`ifndef CELLFIFO_MACROS_SVH
`define CELLFIFO_MACROS_SVH

// pointer width, 2**n entries and one slot kept free
`define CELLFIFO_ADDR_SIZE      4
`define CELLFIFO_DATA_SIZE      32
// flops per synchronizer chain
`define CELLFIFO_SYNC_NUM       3
`define CELLFIFO_RAM_LATENCY    2
// flag thresholds in words
`define CELLFIFO_AEMPTY_NUM     1
`define CELLFIFO_AFULL_NUM      2
// 1 gray pointers through synchronizers, 0 direct binary
`define CELLFIFO_ASYNC_MODE     1

`endif
